// File: hw/mldsa_params_pkg.sv
//**********************************************************
// ML-DSA arithmetic constants and modular helpers mod Q
//**********************************************************
package mldsa_params_pkg;

    localparam int REG_SIZE = 23;
    localparam int PROD_WIDTH = 2 * REG_SIZE;

    localparam logic [REG_SIZE-1:0] MLDSA_Q = 23'd8380417;
    // (Q+1)/2, since Q is odd
    localparam logic [REG_SIZE-1:0] MLDSA_INV2 = REG_SIZE'((MLDSA_Q + 1) >> 1);

    typedef logic [REG_SIZE-1:0] coeff_t;

    // both operands below Q
    function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
        logic [REG_SIZE:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, MLDSA_Q}) begin
            sum = sum - {1'b0, MLDSA_Q};
        end
        return sum[REG_SIZE-1:0];
    endfunction

    function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
        logic [REG_SIZE:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        // wraps in 24 bits, adding Q brings it back into range
        if (a < b) begin
            diff = diff + {1'b0, MLDSA_Q};
        end
        return diff[REG_SIZE-1:0];
    endfunction

    // Q = 2^23 - 2^13 + 1, so 2^23 folds to 2^13 - 1
    // three folds take a product below Q^2 under 2Q
    function automatic coeff_t mod_reduce(input logic [PROD_WIDTH-1:0] x);
        logic [35:0] f1;
        logic [26:0] f2;
        logic [23:0] f3;
        f1 = (36'(x[45:23]) << 13) - 36'(x[45:23]) + 36'(x[22:0]);
        f2 = (27'(f1[35:23]) << 13) - 27'(f1[35:23]) + 27'(f1[22:0]);
        f3 = (24'(f2[26:23]) << 13) - 24'(f2[26:23]) + 24'(f2[22:0]);
        if (f3 >= 24'(MLDSA_Q)) begin
            f3 = f3 - 24'(MLDSA_Q);
        end
        return f3[REG_SIZE-1:0];
    endfunction

endpackage

// File: hw/ntt_masked_pkg.sv
//**********************************************************
// share structs and latencies of the masked NTT datapath
//**********************************************************
package ntt_masked_pkg;

    import mldsa_params_pkg::*;

    // two arithmetic shares, secret = share0 + share1 mod Q
    typedef struct packed {
        coeff_t share0;
        coeff_t share1;
    } masked_coeff_t;

    typedef struct packed {
        masked_coeff_t opu;
        masked_coeff_t opv;
        masked_coeff_t opw;
    } gs_operands_t;

    // fresh randomness, one word per masked operation
    typedef struct packed {
        coeff_t add_r;
        coeff_t sub_r;
        coeff_t mul_r;
    } gs_random_t;

    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
    } gs_results_t;

    localparam int MASKED_ADD_SUB_LATENCY = 2;
    localparam int MASKED_MULT_LATENCY = 4;
    // add/sub, then multiply, then output register
    localparam int GS_BFU_LATENCY = MASKED_ADD_SUB_LATENCY + MASKED_MULT_LATENCY + 1;
    localparam int DIV2_LATENCY = 1;
    localparam int TOP_LATENCY = GS_BFU_LATENCY + DIV2_LATENCY;

endpackage

// File: hw/masked_share_delay.sv
//**********************************************************
// clearable delay line for shares, random words and valids
//**********************************************************
module masked_share_delay #(
    parameter type T = logic,
    parameter int  N = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  T     data_i,
    output T     data_o
);

    T pipe [N];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < N; i++) begin
                pipe[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < N; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= data_i;
            // shift toward the tail
            for (int i = 1; i < N; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign data_o = pipe[N-1];

endmodule

// File: hw/masked_add_sub.sv
//**********************************************************
// masked modular adder / subtractor with output remasking
//**********************************************************
module masked_add_sub #(
    parameter bit SUBTRACT = 1'b0
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  ntt_masked_pkg::masked_coeff_t a_i,
    input  ntt_masked_pkg::masked_coeff_t b_i,
    input  mldsa_params_pkg::coeff_t      r_i,
    output ntt_masked_pkg::masked_coeff_t res_o
);

    import mldsa_params_pkg::*;
    import ntt_masked_pkg::*;

    masked_coeff_t stage1_d;
    masked_coeff_t stage1_q;
    coeff_t        r_q;

    // share-wise operation, shares never combine here
    always_comb begin
        if (SUBTRACT) begin
            stage1_d.share0 = mod_sub(a_i.share0, b_i.share0);
            stage1_d.share1 = mod_sub(a_i.share1, b_i.share1);
        end else begin
            stage1_d.share0 = mod_add(a_i.share0, b_i.share0);
            stage1_d.share1 = mod_add(a_i.share1, b_i.share1);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage1_q <= '0;
            r_q      <= '0;
            res_o    <= '0;
        end else if (zeroize_i) begin
            stage1_q <= '0;
            r_q      <= '0;
            res_o    <= '0;
        end else begin
            stage1_q <= stage1_d;
            r_q      <= r_i;
            // remask: +r on one share, -r on the other
            res_o.share0 <= mod_add(stage1_q.share0, r_q);
            res_o.share1 <= mod_sub(stage1_q.share1, r_q);
        end
    end

    // holds only while callers feed reduced shares and remask
    a_res_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        (res_o.share0 < MLDSA_Q) && (res_o.share1 < MLDSA_Q));

endmodule

// File: hw/masked_mod_mult.sv
//**********************************************************
// two-share masked modular multiplier, cross terms refreshed
//**********************************************************
module masked_mod_mult (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  ntt_masked_pkg::masked_coeff_t a_i,
    input  ntt_masked_pkg::masked_coeff_t b_i,
    input  mldsa_params_pkg::coeff_t      r_i,
    output ntt_masked_pkg::masked_coeff_t res_o
);

    import mldsa_params_pkg::*;
    import ntt_masked_pkg::*;

    // stage 1, raw share products
    logic [PROD_WIDTH-1:0] p00, p01, p10, p11;
    // stage 2, reduced products
    coeff_t m00, m01, m10, m11;
    // stage 3, refreshed cross terms
    coeff_t c00, c01, c10, c11;
    // refresh word follows the operands down the pipe
    coeff_t r_q1, r_q2;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {p00, p01, p10, p11} <= '0;
            {m00, m01, m10, m11} <= '0;
            {c00, c01, c10, c11} <= '0;
            r_q1  <= '0;
            r_q2  <= '0;
            res_o <= '0;
        end else if (zeroize_i) begin
            {p00, p01, p10, p11} <= '0;
            {m00, m01, m10, m11} <= '0;
            {c00, c01, c10, c11} <= '0;
            r_q1  <= '0;
            r_q2  <= '0;
            res_o <= '0;
        end else begin
            p00  <= PROD_WIDTH'(a_i.share0) * PROD_WIDTH'(b_i.share0);
            p01  <= PROD_WIDTH'(a_i.share0) * PROD_WIDTH'(b_i.share1);
            p10  <= PROD_WIDTH'(a_i.share1) * PROD_WIDTH'(b_i.share0);
            p11  <= PROD_WIDTH'(a_i.share1) * PROD_WIDTH'(b_i.share1);
            r_q1 <= r_i;

            m00  <= mod_reduce(p00);
            m01  <= mod_reduce(p01);
            m10  <= mod_reduce(p10);
            m11  <= mod_reduce(p11);
            r_q2 <= r_q1;

            // r cancels once both shares are summed
            c00 <= m00;
            c01 <= mod_add(m01, r_q2);
            c10 <= mod_sub(m10, r_q2);
            c11 <= m11;

            res_o.share0 <= mod_add(c00, c01);
            res_o.share1 <= mod_add(c11, c10);
        end
    end

    // the sub result and delayed twiddle must both arrive reduced
    a_in_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        (a_i.share0 < MLDSA_Q) && (a_i.share1 < MLDSA_Q) &&
        (b_i.share0 < MLDSA_Q) && (b_i.share1 < MLDSA_Q));

endmodule

// File: hw/ntt_masked_gs_butterfly.sv
//**********************************************************
// masked GS butterfly, u+v and (u-v)*w without halving
//**********************************************************
module ntt_masked_gs_butterfly (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         zeroize_i,
    input  ntt_masked_pkg::gs_operands_t operands_i,
    input  ntt_masked_pkg::gs_random_t   rnd_i,
    output ntt_masked_pkg::gs_results_t  results_o
);

    import mldsa_params_pkg::*;
    import ntt_masked_pkg::*;

    masked_coeff_t sum;
    masked_coeff_t diff;
    masked_coeff_t w_dly;
    masked_coeff_t sum_dly;
    masked_coeff_t prod;
    coeff_t        mul_r_dly;

    masked_add_sub #(.SUBTRACT(1'b0)) i_add (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (operands_i.opu),
        .b_i       (operands_i.opv),
        .r_i       (rnd_i.add_r),
        .res_o     (sum)
    );

    masked_add_sub #(.SUBTRACT(1'b1)) i_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (operands_i.opu),
        .b_i       (operands_i.opv),
        .r_i       (rnd_i.sub_r),
        .res_o     (diff)
    );

    // twiddle and its refresh word wait for the difference
    masked_share_delay #(.T(masked_coeff_t), .N(MASKED_ADD_SUB_LATENCY)) i_w_delay (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (operands_i.opw),
        .data_o    (w_dly)
    );

    masked_share_delay #(.T(coeff_t), .N(MASKED_ADD_SUB_LATENCY)) i_mul_r_delay (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (rnd_i.mul_r),
        .data_o    (mul_r_dly)
    );

    masked_mod_mult i_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (diff),
        .b_i       (w_dly),
        .r_i       (mul_r_dly),
        .res_o     (prod)
    );

    // sum waits out the multiplier
    masked_share_delay #(.T(masked_coeff_t), .N(MASKED_MULT_LATENCY)) i_sum_delay (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (sum),
        .data_o    (sum_dly)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            results_o <= '0;
        end else if (zeroize_i) begin
            results_o <= '0;
        end else begin
            results_o.u <= sum_dly;
            results_o.v <= prod;
        end
    end

endmodule

// File: hw/ntt_masked_div2.sv
//**********************************************************
// share-wise halving of butterfly results by 1/2 mod Q
//**********************************************************
module ntt_masked_div2 (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  logic                        valid_i,
    input  ntt_masked_pkg::gs_results_t results_i,
    output ntt_masked_pkg::gs_results_t results_o,
    output logic                        valid_o
);

    import mldsa_params_pkg::*;
    import ntt_masked_pkg::*;

    // halving is linear, so each share is scaled on its own
    function automatic coeff_t halve(input coeff_t x);
        return mod_reduce(PROD_WIDTH'(x) * PROD_WIDTH'(MLDSA_INV2));
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            results_o <= '0;
            valid_o   <= 1'b0;
        end else if (zeroize_i) begin
            results_o <= '0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // hold the last result between strobes
            if (valid_i) begin
                results_o.u.share0 <= halve(results_i.u.share0);
                results_o.u.share1 <= halve(results_i.u.share1);
                results_o.v.share0 <= halve(results_i.v.share0);
                results_o.v.share1 <= halve(results_i.v.share1);
            end
        end
    end

    // zeroize also empties the valid pipe feeding this stage
    a_no_valid_after_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (!valid_o && !valid_i));

endmodule

// File: hw/ntt_masked_bfu_top.sv
//**********************************************************
// masked inverse-NTT butterfly unit with halving stage
//**********************************************************
module ntt_masked_bfu_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         zeroize_i,
    input  logic                         valid_i,
    input  ntt_masked_pkg::gs_operands_t operands_i,
    input  ntt_masked_pkg::gs_random_t   rnd_i,
    output logic                         valid_o,
    output ntt_masked_pkg::gs_results_t  results_o
);

    import ntt_masked_pkg::*;

    gs_results_t bfu_results;
    logic        bfu_valid;

    ntt_masked_gs_butterfly i_gs_butterfly (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .operands_i (operands_i),
        .rnd_i      (rnd_i),
        .results_o  (bfu_results)
    );

    // valid rides alongside the butterfly pipeline
    masked_share_delay #(.T(logic), .N(GS_BFU_LATENCY)) i_valid_delay (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (valid_i),
        .data_o    (bfu_valid)
    );

    ntt_masked_div2 i_div2 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (bfu_valid),
        .results_i (bfu_results),
        .results_o (results_o),
        .valid_o   (valid_o)
    );

endmodule

// File: sim/tb_ntt_masked_bfu.sv
//**********************************************************
// directed testbench for the masked inverse-NTT butterfly
//**********************************************************
module tb_ntt_masked_bfu;

    timeunit 1ns;
    timeprecision 1ps;

    import mldsa_params_pkg::*;
    import ntt_masked_pkg::*;

    localparam logic [63:0] Q         = 64'd8380417;
    localparam logic [63:0] INV2      = 64'd4190209;
    localparam int          LATENCY   = 8;
    localparam int          TOTAL_OPS = 8 + 4 + 16 + 27 + 4;

    typedef struct packed {
        logic [63:0] u;
        logic [63:0] v;
        logic [63:0] cycle;
    } expect_t;

    logic         clk;
    logic         reset_n;
    logic         zeroize_i;
    logic         valid_i;
    gs_operands_t operands_i;
    gs_random_t   rnd_i;
    logic         valid_o;
    gs_results_t  results_o;

    logic [31:0]  lfsr_state = 32'd5473;
    logic [63:0]  cycle_cnt = 64'd0;
    expect_t      exp_q [$];
    int           value_errors = 0;
    int           proto_errors = 0;

    ntt_masked_bfu_top i_ntt_masked_bfu_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .valid_i    (valid_i),
        .operands_i (operands_i),
        .rnd_i      (rnd_i),
        .valid_o    (valid_o),
        .results_o  (results_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 64'd1;
    end

    // galois LFSR, one step per bit taken
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic logic [63:0] rand_mod_q();
        logic [63:0] raw;
        raw = 64'd0;
        for (int i = 0; i < 23; i++) begin
            raw = {raw[62:0], next_bit()};
        end
        return raw % Q;
    endfunction

    function automatic masked_coeff_t split_secret(input logic [63:0] s);
        masked_coeff_t m;
        logic [63:0]   r;
        r = rand_mod_q();
        m.share0 = coeff_t'(r);
        m.share1 = coeff_t'((s + Q - r) % Q);
        return m;
    endfunction

    function automatic logic [63:0] unmask(input masked_coeff_t m);
        return (64'(m.share0) + 64'(m.share1)) % Q;
    endfunction

    // drive one strobe, optionally record the reference result
    task automatic send_op(input logic [63:0] u, input logic [63:0] v,
                           input logic [63:0] w, input bit track);
        gs_operands_t ops;
        gs_random_t   rnd;
        expect_t      e;
        ops.opu = split_secret(u);
        ops.opv = split_secret(v);
        ops.opw = split_secret(w);
        rnd.add_r = coeff_t'(rand_mod_q());
        rnd.sub_r = coeff_t'(rand_mod_q());
        rnd.mul_r = coeff_t'(rand_mod_q());
        @(negedge clk);
        operands_i = ops;
        rnd_i      = rnd;
        valid_i    = 1'b1;
        if (track) begin
            e.u = (((u + v) % Q) * INV2) % Q;
            e.v = (((((u + Q - v) % Q) * w) % Q) * INV2) % Q;
            // seen at the falling edge LATENCY cycles later
            e.cycle = cycle_cnt + 64'(LATENCY);
            exp_q.push_back(e);
        end
    endtask

    task automatic end_burst();
        @(negedge clk);
        valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            proto_errors++;
            $display("timeout: %0d results never arrived", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic check_idle_outputs();
        if (valid_o !== 1'b0) begin
            value_errors++;
            $display("ERR valid_o: got %h expected %h", valid_o, 1'b0);
        end
        if (results_o !== '0) begin
            value_errors++;
            $display("ERR results_o: got %h expected %h", results_o, 92'h0);
        end
    endtask

    task automatic test_reset_state();
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
    endtask

    task automatic test_single(input int n);
        for (int i = 0; i < n; i++) begin
            send_op(rand_mod_q(), rand_mod_q(), rand_mod_q(), 1'b1);
            end_burst();
            wait_drain();
        end
    endtask

    // same secrets, fresh shares and masks each time
    task automatic test_mask_independence();
        logic [63:0] u, v, w;
        logic [63:0] first_u, first_v;
        for (int i = 0; i < 2; i++) begin
            u = rand_mod_q();
            v = rand_mod_q();
            w = rand_mod_q();
            for (int k = 0; k < 2; k++) begin
                send_op(u, v, w, 1'b1);
                end_burst();
                wait_drain();
                @(negedge clk);
                if (k == 0) begin
                    first_u = unmask(results_o.u);
                    first_v = unmask(results_o.v);
                end else begin
                    if (unmask(results_o.u) != first_u) begin
                        value_errors++;
                        $display("ERR results_o.u: got %h expected %h",
                                 unmask(results_o.u), first_u);
                    end
                    if (unmask(results_o.v) != first_v) begin
                        value_errors++;
                        $display("ERR results_o.v: got %h expected %h",
                                 unmask(results_o.v), first_v);
                    end
                end
            end
        end
    endtask

    task automatic test_streaming();
        for (int i = 0; i < 16; i++) begin
            send_op(rand_mod_q(), rand_mod_q(), rand_mod_q(), 1'b1);
        end
        end_burst();
        wait_drain();
    endtask

    task automatic test_edge_values();
        logic [63:0] edge_vals [3];
        edge_vals[0] = 64'd0;
        edge_vals[1] = 64'd1;
        edge_vals[2] = Q - 64'd1;
        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
                for (int c = 0; c < 3; c++) begin
                    send_op(edge_vals[a], edge_vals[b], edge_vals[c], 1'b1);
                end
            end
        end
        end_burst();
        wait_drain();
    endtask

    // untracked ops, so any valid_o from them is flagged by the monitor
    task automatic test_zeroize();
        for (int i = 0; i < 3; i++) begin
            send_op(rand_mod_q(), rand_mod_q(), rand_mod_q(), 1'b0);
        end
        end_burst();
        @(negedge clk);
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i = 1'b0;
        check_idle_outputs();
        repeat (12) @(negedge clk);
        check_idle_outputs();
        send_op(rand_mod_q(), rand_mod_q(), rand_mod_q(), 1'b1);
        end_burst();
        wait_drain();
    endtask

    always @(negedge clk) begin : monitor
        expect_t     e;
        logic [63:0] got_u;
        logic [63:0] got_v;
        if (reset_n && valid_o) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("valid_o asserted with no operation outstanding, cycle %0d",
                         cycle_cnt);
            end else begin
                e = exp_q.pop_front();
                if (cycle_cnt != e.cycle) begin
                    proto_errors++;
                    $display("valid_o arrived at cycle %0d instead of cycle %0d",
                             cycle_cnt, e.cycle);
                end
                got_u = unmask(results_o.u);
                got_v = unmask(results_o.v);
                if (got_u != e.u) begin
                    value_errors++;
                    $display("ERR results_o.u: got %h expected %h", got_u, e.u);
                end
                if (got_v != e.v) begin
                    value_errors++;
                    $display("ERR results_o.v: got %h expected %h", got_v, e.v);
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 20 + 200) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize_i  = 1'b0;
        valid_i    = 1'b0;
        operands_i = '0;
        rnd_i      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        test_reset_state();
        test_single(8);
        test_mask_independence();
        test_streaming();
        test_edge_values();
        test_zeroize();
        repeat (3) @(negedge clk);

        $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
hw/mldsa_params_pkg.sv
hw/ntt_masked_pkg.sv
hw/masked_share_delay.sv
hw/masked_add_sub.sv
hw/masked_mod_mult.sv
hw/ntt_masked_gs_butterfly.sv
hw/ntt_masked_div2.sv
hw/ntt_masked_bfu_top.sv
sim/tb_ntt_masked_bfu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the masked butterfly testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_ntt_masked_bfu -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
